/* logic/xm_pkg.sv */
// register block shared definitions
// bus and memory widths, register numbers, tick timer constants
package xm_pkg;

    typedef logic [7:0]  byte_t;            // host bus byte
    typedef logic [15:0] word_t;            // register or memory data word
    typedef logic [15:0] addr_t;            // vram or xr address
    typedef logic [3:0]  reg_num_t;         // host register number
    typedef logic [6:0]  intr_t;            // interrupt mask/clear/status
    typedef logic [3:0]  wrmask_t;          // vram nibble write enables

    // host visible register map
    localparam reg_num_t XM_SYS_CTRL = 4'd0;   // wrmask, busy and blank status
    localparam reg_num_t XM_INT_CTRL = 4'd1;   // intr mask, clear, status
    localparam reg_num_t XM_TIMER    = 4'd2;   // 1/10 ms free running count
    localparam reg_num_t XM_RD_XADDR = 4'd3;
    localparam reg_num_t XM_WR_XADDR = 4'd4;
    localparam reg_num_t XM_XDATA    = 4'd5;
    localparam reg_num_t XM_RD_INCR  = 4'd6;
    localparam reg_num_t XM_RD_ADDR  = 4'd7;
    localparam reg_num_t XM_WR_INCR  = 4'd8;
    localparam reg_num_t XM_WR_ADDR  = 4'd9;
    localparam reg_num_t XM_DATA     = 4'd10;
    localparam reg_num_t XM_DATA_2   = 4'd11;  // alias of XM_DATA
    // 12..15 unused, read as zero

    // tick timer: 10/25000 of a tick per clock, i.e. one tick per 2500 clocks
    localparam int PCLK_HZ           = 25_000_000;
    localparam int TIMER_CLK_REDUCED = PCLK_HZ / 1000;
    localparam int TIMER_HZ_REDUCED  = 10;
    localparam int TIMER_FRAC_BITS   = $clog2(TIMER_CLK_REDUCED) + 1;   // one extra for sign

    typedef logic signed [TIMER_FRAC_BITS-1:0] frac_t;  // divider accumulator

    // SYS_CTRL status bit positions
    localparam int SYS_CTRL_BUSY_BIT   = 15;    // mem_wait
    localparam int SYS_CTRL_HBLANK_BIT = 10;
    localparam int SYS_CTRL_VBLANK_BIT = 9;

endpackage

/* logic/xm_bus_if.sv */
// decoded host bus byte events
// synchronizer drives, memory port and register file consume
`timescale 1ns/1ps

interface xm_bus_if import xm_pkg::*; ();

    logic     write_strobe;     // one clock per write cycle
    logic     read_strobe;      // one clock per read cycle
    reg_num_t reg_num;          // held until next bus cycle
    logic     bytesel;          // 0 even (high) byte, 1 odd (low) byte
    byte_t    data;             // write data byte

    modport src (output write_strobe, read_strobe, reg_num, bytesel, data);
    modport dst (input  write_strobe, read_strobe, reg_num, bytesel, data);

endinterface

/* logic/xm_mem_regs_if.sv */
// memory port register values for host readback
// owned by the memory port, viewed by the register file
`timescale 1ns/1ps

interface xm_mem_regs_if import xm_pkg::*; ();

    addr_t rd_xaddr;            // xr read address
    addr_t wr_xaddr;            // xr write address
    word_t xdata;               // last xr read word
    word_t rd_incr;             // vram read step
    addr_t rd_addr;             // vram read address
    word_t wr_incr;             // vram write step
    addr_t wr_addr;             // vram write address
    word_t data;                // last vram read word
    logic  busy;                // mem_wait status

    modport owner (output rd_xaddr, wr_xaddr, xdata, rd_incr, rd_addr,
                          wr_incr, wr_addr, data, busy);
    modport view  (input  rd_xaddr, wr_xaddr, xdata, rd_incr, rd_addr,
                          wr_incr, wr_addr, data, busy);

endinterface

/* logic/xm_bus_sync.sv */
// host bus synchronizer
// brings the async chip select into the clock domain and turns each
// select into a single read or write strobe with latched bus fields
`timescale 1ns/1ps

module xm_bus_sync import xm_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     bus_cs_n_i,       // async select, active low
    input  wire logic     bus_rd_nwr_i,     // 1 read, 0 write
    input  wire reg_num_t bus_reg_num_i,
    input  wire logic     bus_bytesel_i,    // 0 even, 1 odd
    input  wire byte_t    bus_data_i,
    xm_bus_if.src         bus
);

    logic [1:0] cs_n_sync;      // [0] may be metastable, [1] is safe
    logic       cs_n_last;      // previous safe value for edge detect
    logic       cs_fall;

    assign cs_fall = cs_n_last & ~cs_n_sync[1];    // select just asserted

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync        <= 2'b11;              // idle, no false edge
            cs_n_last        <= 1'b1;
            bus.write_strobe <= 1'b0;
            bus.read_strobe  <= 1'b0;
            bus.reg_num      <= '0;
            bus.bytesel      <= 1'b0;
            bus.data         <= '0;
        end else begin
            cs_n_sync        <= {cs_n_sync[0], bus_cs_n_i};
            cs_n_last        <= cs_n_sync[1];
            bus.write_strobe <= cs_fall & ~bus_rd_nwr_i;
            bus.read_strobe  <= cs_fall & bus_rd_nwr_i;
            // other pins have been stable for two clocks by now
            if (cs_fall) begin
                bus.reg_num <= bus_reg_num_i;
                bus.bytesel <= bus_bytesel_i;
                bus.data    <= bus_data_i;
            end
        end
    end

endmodule

/* logic/xm_tick_timer.sv */
// 1/10 ms tick timer
// fractional divider on the pixel clock feeding a 16-bit free running count
`timescale 1ns/1ps

module xm_tick_timer import xm_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    output      word_t timer_o      // tenths of a millisecond, wraps
);

    frac_t frac;                    // signed fraction accumulator
    logic  tick;

    assign tick = ~frac[TIMER_FRAC_BITS-1];     // non-negative means a tick is due

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (tick) begin
            frac    <= frac + frac_t'(TIMER_HZ_REDUCED - TIMER_CLK_REDUCED);
            timer_o <= timer_o + 1'b1;
        end else begin
            frac    <= frac + frac_t'(TIMER_HZ_REDUCED);
        end
    end

endmodule

/* logic/xm_mem_port.sv */
// vram and xr memory port
// address, increment and data registers behind the host bus, issues
// read and write requests and steps addresses after each ack
`timescale 1ns/1ps

module xm_mem_port import xm_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    xm_bus_if.dst      bus,
    xm_mem_regs_if.owner regs,
    input  wire logic  vram_ack_i,
    input  wire logic  xr_ack_i,
    output      logic  vram_sel_o,      // held until vram_ack_i
    output      logic  xr_sel_o,        // held until xr_ack_i
    output      logic  wr_o,            // 1 write, 0 read
    output      addr_t addr_o,
    output      word_t data_o,
    input  wire word_t vram_data_i,
    input  wire word_t xr_data_i
);

    addr_t rd_xaddr, wr_xaddr, rd_addr, wr_addr;
    word_t rd_incr, wr_incr;
    word_t data;                // vram pre-read result
    word_t xdata;               // xr pre-read result
    byte_t data_even;           // staged high byte of a DATA write
    byte_t xdata_even;          // staged high byte of an XDATA write
    logic  vram_rd, xr_rd;      // read outstanding
    logic  rd_step, wr_step;    // vram address step pending
    logic  xrd_step, xwr_step;  // xr address step pending
    logic  wr_odd, rd_odd;      // odd byte strobes

    assign wr_odd = bus.write_strobe & bus.bytesel;
    assign rd_odd = bus.read_strobe & bus.bytesel;

    assign regs.rd_xaddr = rd_xaddr;
    assign regs.wr_xaddr = wr_xaddr;
    assign regs.xdata    = xdata;
    assign regs.rd_incr  = rd_incr;
    assign regs.rd_addr  = rd_addr;
    assign regs.wr_incr  = wr_incr;
    assign regs.wr_addr  = wr_addr;
    assign regs.data     = data;
    // busy until the address has stepped, not just until ack
    assign regs.busy = wr_o | vram_rd | xr_rd | rd_step | wr_step | xrd_step | xwr_step;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            xr_sel_o   <= 1'b0;
            wr_o       <= 1'b0;
            vram_rd    <= 1'b0;
            xr_rd      <= 1'b0;
            rd_step    <= 1'b0;
            wr_step    <= 1'b0;
            xrd_step   <= 1'b0;
            xwr_step   <= 1'b0;
            addr_o     <= '0;
            data_o     <= '0;
            rd_xaddr   <= '0;
            wr_xaddr   <= '0;
            rd_addr    <= '0;
            wr_addr    <= '0;
            rd_incr    <= '0;
            wr_incr    <= '0;
            data       <= '0;
            xdata      <= '0;
            data_even  <= '0;
            xdata_even <= '0;
        end else begin
            rd_step  <= vram_ack_i & vram_rd;       // flag cycle, add next
            wr_step  <= vram_ack_i & wr_o;
            xrd_step <= xr_ack_i & xr_rd;
            xwr_step <= xr_ack_i & wr_o;

            if (vram_ack_i) begin
                if (vram_rd) data <= vram_data_i;
                vram_sel_o <= 1'b0;
                wr_o       <= 1'b0;
                vram_rd    <= 1'b0;
            end
            if (xr_ack_i) begin
                if (xr_rd) xdata <= xr_data_i;
                xr_sel_o <= 1'b0;
                wr_o     <= 1'b0;
                xr_rd    <= 1'b0;
            end

            if (rd_step)  rd_addr  <= rd_addr + rd_incr;
            if (wr_step)  wr_addr  <= wr_addr + wr_incr;
            if (xrd_step) rd_xaddr <= rd_xaddr + 1'b1;   // xr always steps by one
            if (xwr_step) wr_xaddr <= wr_xaddr + 1'b1;

            // even byte goes to bits 15:8, odd byte to 7:0
            if (bus.write_strobe) begin
                case (bus.reg_num)
                    XM_RD_XADDR: begin
                        if (!bus.bytesel) rd_xaddr[15:8] <= bus.data;
                        else              rd_xaddr[7:0]  <= bus.data;
                    end
                    XM_WR_XADDR: begin
                        if (!bus.bytesel) wr_xaddr[15:8] <= bus.data;
                        else              wr_xaddr[7:0]  <= bus.data;
                    end
                    XM_XDATA:    if (!bus.bytesel) xdata_even <= bus.data;
                    XM_RD_INCR: begin
                        if (!bus.bytesel) rd_incr[15:8] <= bus.data;
                        else              rd_incr[7:0]  <= bus.data;
                    end
                    XM_RD_ADDR: begin
                        if (!bus.bytesel) rd_addr[15:8] <= bus.data;
                        else              rd_addr[7:0]  <= bus.data;
                    end
                    XM_WR_INCR: begin
                        if (!bus.bytesel) wr_incr[15:8] <= bus.data;
                        else              wr_incr[7:0]  <= bus.data;
                    end
                    XM_WR_ADDR: begin
                        if (!bus.bytesel) wr_addr[15:8] <= bus.data;
                        else              wr_addr[7:0]  <= bus.data;
                    end
                    XM_DATA, XM_DATA_2: if (!bus.bytesel) data_even <= bus.data;
                    default: ;                      // control regs live elsewhere
                endcase
            end

            // requests come last so they win over an ack clear in the same cycle
            if (wr_odd && bus.reg_num == XM_RD_XADDR) begin
                xr_sel_o <= 1'b1;                   // pre-read at new address
                xr_rd    <= 1'b1;
                addr_o   <= {rd_xaddr[15:8], bus.data};
            end
            if (wr_odd && bus.reg_num == XM_RD_ADDR) begin
                vram_sel_o <= 1'b1;
                vram_rd    <= 1'b1;
                addr_o     <= {rd_addr[15:8], bus.data};
            end
            if (wr_odd && bus.reg_num == XM_XDATA) begin
                xr_sel_o <= 1'b1;
                wr_o     <= 1'b1;
                addr_o   <= wr_xaddr;
                data_o   <= {xdata_even, bus.data};  // staged even + odd byte
            end
            if (wr_odd && (bus.reg_num == XM_DATA || bus.reg_num == XM_DATA_2)) begin
                vram_sel_o <= 1'b1;
                wr_o       <= 1'b1;
                addr_o     <= wr_addr;
                data_o     <= {data_even, bus.data};
            end
            if (rd_odd && bus.reg_num == XM_XDATA) begin
                xr_sel_o <= 1'b1;                   // fetch next word for host
                xr_rd    <= 1'b1;
                addr_o   <= rd_xaddr;
            end
            if (rd_odd && (bus.reg_num == XM_DATA || bus.reg_num == XM_DATA_2)) begin
                vram_sel_o <= 1'b1;
                vram_rd    <= 1'b1;
                addr_o     <= rd_addr;
            end
        end
    end

endmodule

/* logic/xm_reg_file.sv */
// control registers and host readback
// SYS_CTRL write mask, INT_CTRL mask and clear pulse, timer low byte latch,
// plus the byte mux that puts any register on the host data bus
`timescale 1ns/1ps

module xm_reg_file import xm_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset_i,
    xm_bus_if.dst        bus,
    xm_mem_regs_if.view  regs,
    input  wire word_t   timer_i,
    input  wire logic    h_blank_i,
    input  wire logic    v_blank_i,
    input  wire intr_t   intr_status_i,     // pending interrupts
    output      wrmask_t wrmask_o,          // vram nibble enables
    output      intr_t   intr_mask_o,       // enabled interrupts
    output      intr_t   intr_clear_o,      // one clock clear pulse
    output      byte_t   bus_data_o
);

    byte_t timer_lo;            // low timer byte frozen at high byte read
    word_t rd_word;             // selected register, full word
    logic  wr_even, wr_odd;

    assign wr_even = bus.write_strobe & ~bus.bytesel;
    assign wr_odd  = bus.write_strobe & bus.bytesel;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask_o     <= '1;                 // all nibbles writable
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            timer_lo     <= '0;
        end else begin
            intr_clear_o <= '0;                 // pulse only
            if (wr_odd && bus.reg_num == XM_SYS_CTRL) wrmask_o <= bus.data[3:0];
            if (wr_even && bus.reg_num == XM_INT_CTRL) intr_mask_o <= bus.data[6:0];
            if (wr_odd && bus.reg_num == XM_INT_CTRL) intr_clear_o <= bus.data[6:0];
            // any even read, so a 16-bit timer read is coherent
            if (bus.read_strobe && !bus.bytesel) timer_lo <= timer_i[7:0];
        end
    end

    always_comb begin
        rd_word = '0;                           // 12..15 and unused bits
        case (bus.reg_num)
            XM_SYS_CTRL: begin
                rd_word[SYS_CTRL_BUSY_BIT]   = regs.busy;
                rd_word[SYS_CTRL_HBLANK_BIT] = h_blank_i;
                rd_word[SYS_CTRL_VBLANK_BIT] = v_blank_i;
                rd_word[3:0]                 = wrmask_o;
            end
            XM_INT_CTRL:        rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            XM_TIMER:           rd_word = {timer_i[15:8], timer_lo};
            XM_RD_XADDR:        rd_word = regs.rd_xaddr;
            XM_WR_XADDR:        rd_word = regs.wr_xaddr;
            XM_XDATA:           rd_word = regs.xdata;
            XM_RD_INCR:         rd_word = regs.rd_incr;
            XM_RD_ADDR:         rd_word = regs.rd_addr;
            XM_WR_INCR:         rd_word = regs.wr_incr;
            XM_WR_ADDR:         rd_word = regs.wr_addr;
            XM_DATA, XM_DATA_2: rd_word = regs.data;
            default:            rd_word = '0;
        endcase
    end

    // even byte is the high half
    assign bus_data_o = bus.bytesel ? rd_word[7:0] : rd_word[15:8];

endmodule

/* logic/xm_reg_top.sv */
// host register block top
// bus synchronizer, tick timer, memory port and register file
// joined through the bus event and memory register interfaces
`timescale 1ns/1ps

module xm_reg_top import xm_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset_i,
    // host bus
    input  wire logic     bus_cs_n_i,
    input  wire logic     bus_rd_nwr_i,
    input  wire reg_num_t bus_reg_num_i,
    input  wire logic     bus_bytesel_i,
    input  wire byte_t    bus_data_i,
    output      byte_t    bus_data_o,
    // vram / xr memory side
    input  wire logic     vram_ack_i,
    input  wire logic     xr_ack_i,
    output      logic     vram_sel_o,
    output      logic     xr_sel_o,
    output      logic     wr_o,
    output      wrmask_t  wrmask_o,
    output      addr_t    addr_o,
    output      word_t    data_o,
    input  wire word_t    vram_data_i,
    input  wire word_t    xr_data_i,
    // status and interrupts
    input  wire logic     h_blank_i,
    input  wire logic     v_blank_i,
    input  wire intr_t    intr_status_i,
    output      intr_t    intr_mask_o,
    output      intr_t    intr_clear_o
);

    word_t timer;               // free running 1/10 ms count

    xm_bus_if      bus_if ();   // strobes and latched bus fields
    xm_mem_regs_if regs_if ();  // memory port state for readback

    xm_bus_sync u_bus_sync (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i,
        .bus_bytesel_i, .bus_data_i,
        .bus (bus_if.src)
    );

    xm_tick_timer u_tick_timer (.clk, .reset_i, .timer_o (timer));

    xm_mem_port u_mem_port (
        .clk, .reset_i,
        .bus (bus_if.dst), .regs (regs_if.owner),
        .vram_ack_i, .xr_ack_i, .vram_sel_o, .xr_sel_o, .wr_o,
        .addr_o, .data_o, .vram_data_i, .xr_data_i
    );

    xm_reg_file u_reg_file (
        .clk, .reset_i,
        .bus (bus_if.dst), .regs (regs_if.view),
        .timer_i (timer), .h_blank_i, .v_blank_i, .intr_status_i,
        .wrmask_o, .intr_mask_o, .intr_clear_o, .bus_data_o
    );

endmodule

/* testbench/tb_xm_tasks.svh */
// host bus helper tasks for the register block testbench
// one byte cycle holds cs_n low for 6 clocks and high for 4
// inputs change on the falling edge
`ifndef TB_XM_TASKS_SVH
`define TB_XM_TASKS_SVH

task automatic bus_write(input reg_num_t rn, input logic odd, input byte_t val);
    bus_reg_num_i = rn;
    bus_bytesel_i = odd;
    bus_rd_nwr_i  = 1'b0;
    bus_data_i    = val;
    bus_cs_n_i    = 1'b0;
    repeat (6) @(negedge clk);
    bus_cs_n_i = 1'b1;
    repeat (4) @(negedge clk);
endtask

task automatic bus_read(input reg_num_t rn, input logic odd, output byte_t val);
    bus_reg_num_i = rn;
    bus_bytesel_i = odd;
    bus_rd_nwr_i  = 1'b1;
    bus_cs_n_i    = 1'b0;
    repeat (4) @(negedge clk);
    val = bus_data_o;                   // strobe done and any new fetch not yet landed
    repeat (2) @(negedge clk);
    bus_cs_n_i = 1'b1;
    repeat (4) @(negedge clk);
endtask

task automatic write_word(input reg_num_t rn, input word_t val);
    bus_write(rn, 1'b0, val[15:8]);     // even byte is the high half
    bus_write(rn, 1'b1, val[7:0]);
endtask

task automatic read_word(input reg_num_t rn, output word_t val);
    bus_read(rn, 1'b0, val[15:8]);
    bus_read(rn, 1'b1, val[7:0]);
endtask

// poll mem_wait in SYS_CTRL for at most POLL_LIMIT reads
task automatic wait_mem_idle();
    byte_t st;
    bit    idle;
    idle = 1'b0;
    for (int i = 0; i < POLL_LIMIT && !idle; i++) begin
        bus_read(XM_SYS_CTRL, 1'b0, st);
        idle = !st[7];                  // bit 15 of the word
    end
    if (!idle) begin
        timeouts++;
        $display("timeout: memory port still busy after %0d polls", POLL_LIMIT);
    end
endtask

`endif

/* testbench/tb_xm_reg_top.sv */
// testbench for the host register block
// vram and xr responder models, protocol assertions and a directed test sequence
`timescale 1ns/1ps

module tb_xm_reg_top import xm_pkg::*; ();

    localparam int WATCHDOG_CYCLES = 50000;
    localparam int POLL_LIMIT      = 20;
    localparam int MEM_DEPTH       = 256;
    localparam int TICK_CLOCKS     = PCLK_HZ / 10_000;     // clocks per 1/10 ms
    localparam int TIMER_GAP       = 6000;

    logic     clk, reset_i;
    logic     bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    reg_num_t bus_reg_num_i;
    byte_t    bus_data_i, bus_data_o;
    logic     vram_ack_i, xr_ack_i, vram_sel_o, xr_sel_o, wr_o;
    wrmask_t  wrmask_o;
    addr_t    addr_o;
    word_t    data_o, vram_data_i, xr_data_i;
    logic     h_blank_i, v_blank_i;
    intr_t    intr_status_i, intr_mask_o, intr_clear_o;

    integer seed = 67970;
    int     checks, value_errors, protocol_errors, timeouts;
    int     vram_wait, xr_wait;                 // responder countdowns
    word_t  vram_mem [MEM_DEPTH];
    word_t  xr_mem [MEM_DEPTH];
    addr_t  vram_wr_addr, xr_wr_addr;           // last write each model took
    word_t  vram_wr_data, xr_wr_data;
    int     clear_cycles;
    intr_t  clear_val;

    xm_reg_top u_dut (.*);

    `include "tb_xm_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // vram responder acks 1 to 4 clocks after select
    always @(negedge clk) begin
        if (reset_i || vram_ack_i) begin
            vram_ack_i = 1'b0;                  // ack lasts one cycle
            vram_wait  = 0;
        end else if (vram_sel_o) begin
            if (vram_wait == 0) vram_wait = 1 + {$random(seed)} % 4;
            vram_wait = vram_wait - 1;
            if (vram_wait == 0) begin
                vram_ack_i = 1'b1;
                if (wr_o) begin
                    vram_mem[addr_o[7:0]] = data_o;
                    vram_wr_addr = addr_o;
                    vram_wr_data = data_o;
                end else begin
                    vram_data_i = vram_mem[addr_o[7:0]];
                end
            end
        end
    end

    // xr responder with the same timing
    always @(negedge clk) begin
        if (reset_i || xr_ack_i) begin
            xr_ack_i = 1'b0;
            xr_wait  = 0;
        end else if (xr_sel_o) begin
            if (xr_wait == 0) xr_wait = 1 + {$random(seed)} % 4;
            xr_wait = xr_wait - 1;
            if (xr_wait == 0) begin
                xr_ack_i = 1'b1;
                if (wr_o) begin
                    xr_mem[addr_o[7:0]] = data_o;
                    xr_wr_addr = addr_o;
                    xr_wr_data = data_o;
                end else begin
                    xr_data_i = xr_mem[addr_o[7:0]];
                end
            end
        end
    end

    always @(negedge clk) begin
        if (intr_clear_o != '0) begin
            clear_cycles++;                     // width of the clear pulse
            clear_val = intr_clear_o;
        end
    end

    vram_hold: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_ack_i) |=> vram_sel_o && $stable(addr_o) && $stable(data_o))
        else begin
            protocol_errors++;
            $display("vram request dropped or changed before its ack");
        end

    xr_hold: assert property (@(posedge clk) disable iff (reset_i)
        (xr_sel_o && !xr_ack_i) |=> xr_sel_o && $stable(addr_o) && $stable(data_o))
        else begin
            protocol_errors++;
            $display("xr request dropped or changed before its ack");
        end

    clear_pulse: assert property (@(posedge clk) disable iff (reset_i)
        (intr_clear_o != '0) |=> (intr_clear_o == '0))
        else begin
            protocol_errors++;
            $display("intr_clear_o stayed high longer than one cycle");
        end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic end_run(input bit timed_out);
        $display("checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 checks, value_errors, protocol_errors, timeouts);
        if (timed_out || value_errors != 0 || protocol_errors != 0 || timeouts != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES);
        end_run(1'b1);
    end

    initial begin
        word_t    w, exp, t1, t2;
        byte_t    b;
        reg_num_t plain_regs [3];
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        vram_ack_i    = 1'b0;
        xr_ack_i      = 1'b0;
        vram_data_i   = '0;
        xr_data_i     = '0;
        h_blank_i     = 1'b0;
        v_blank_i     = 1'b0;
        intr_status_i = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            vram_mem[i] = {8'(i) ^ 8'hC3, 8'(i)};       // both halves track the address
            xr_mem[i]   = {~8'(i), 8'(i) ^ 8'h69};
        end
        plain_regs = '{XM_RD_INCR, XM_WR_INCR, XM_WR_XADDR};
        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        check_value("wrmask_o", 16'h000F, wrmask_o);
        check_value("vram_sel_o", 16'h0, vram_sel_o);
        check_value("xr_sel_o", 16'h0, xr_sel_o);
        check_value("intr_clear_o", 16'h0, intr_clear_o);
        for (int i = 0; i < 3; i++) begin
            exp = $random(seed);
            write_word(plain_regs[i], exp);
            read_word(plain_regs[i], w);
            check_value($sformatf("register %0d", plain_regs[i]), exp, w);
        end

        // vram write at 0x0010 with a step of 3
        write_word(XM_WR_ADDR, 16'h0010);
        write_word(XM_WR_INCR, 16'h0003);
        write_word(XM_DATA, 16'hA55A);
        wait_mem_idle();
        check_value("vram addr_o", 16'h0010, vram_wr_addr);
        check_value("vram data_o", 16'hA55A, vram_wr_data);
        read_word(XM_WR_ADDR, w);
        check_value("WR_ADDR", 16'h0013, w);

        // vram reads from 0x0020 with a step of 2
        write_word(XM_RD_INCR, 16'h0002);
        write_word(XM_RD_ADDR, 16'h0020);
        wait_mem_idle();
        for (int k = 0; k < 3; k++) begin
            read_word(XM_DATA, w);
            check_value("DATA", vram_mem[8'h20 + 2 * k], w);
            wait_mem_idle();
        end
        bus_read(XM_SYS_CTRL, 1'b0, b);
        check_value("SYS_CTRL busy", 16'h0, b[7]);
        read_word(XM_RD_ADDR, w);
        check_value("RD_ADDR", 16'h0028, w);

        // xr write then pre-read and one data read
        write_word(XM_WR_XADDR, 16'h0040);
        write_word(XM_XDATA, 16'h1234);
        wait_mem_idle();
        check_value("xr addr_o", 16'h0040, xr_wr_addr);
        check_value("xr data_o", 16'h1234, xr_wr_data);
        read_word(XM_WR_XADDR, w);
        check_value("WR_XADDR", 16'h0041, w);
        write_word(XM_RD_XADDR, 16'h0050);
        wait_mem_idle();
        read_word(XM_RD_XADDR, w);
        check_value("RD_XADDR", 16'h0051, w);
        read_word(XM_XDATA, w);
        check_value("XDATA", xr_mem[8'h50], w);
        wait_mem_idle();
        read_word(XM_RD_XADDR, w);
        check_value("RD_XADDR", 16'h0052, w);

        // control registers
        h_blank_i     = 1'b1;
        intr_status_i = 7'h51;
        bus_write(XM_SYS_CTRL, 1'b1, 8'h05);
        check_value("wrmask_o", 16'h0005, wrmask_o);
        read_word(XM_SYS_CTRL, w);
        check_value("SYS_CTRL", 16'h0405, w);       // h_blank in bit 10
        h_blank_i = 1'b0;
        v_blank_i = 1'b1;
        read_word(XM_SYS_CTRL, w);
        check_value("SYS_CTRL", 16'h0205, w);       // v_blank in bit 9
        bus_write(XM_INT_CTRL, 1'b0, 8'h2A);
        check_value("intr_mask_o", 16'h002A, intr_mask_o);
        clear_cycles = 0;
        bus_write(XM_INT_CTRL, 1'b1, 8'h33);
        check_value("intr_clear_o cycles", 16'd1, clear_cycles);
        check_value("intr_clear_o", 16'h0033, clear_val);
        read_word(XM_INT_CTRL, w);
        check_value("INT_CTRL", {1'b0, 7'h2A, 1'b0, 7'h51}, w);

        // two coherent timer reads TIMER_GAP clocks apart
        read_word(XM_TIMER, t1);
        repeat (TIMER_GAP - 20) @(negedge clk);     // one word read is 20 clocks
        read_word(XM_TIMER, t2);
        checks++;
        assert (t2 - t1 inside {[TIMER_GAP / TICK_CLOCKS : TIMER_GAP / TICK_CLOCKS + 1]})
        else begin
            value_errors++;
            $display("CHECK FAILED TIMER delta expected 0x%h or 0x%h got 0x%h",
                     TIMER_GAP / TICK_CLOCKS, TIMER_GAP / TICK_CLOCKS + 1, t2 - t1);
        end

        end_run(1'b0);
    end

endmodule

/* filelist.f */
+incdir+testbench
logic/xm_pkg.sv
logic/xm_bus_if.sv
logic/xm_mem_regs_if.sv
logic/xm_bus_sync.sv
logic/xm_tick_timer.sv
logic/xm_mem_port.sv
logic/xm_reg_file.sv
logic/xm_reg_top.sv
testbench/tb_xm_reg_top.sv

/* Bender.yml */
package:
  name: xm_reg_block

sources:
  - files:
      - logic/xm_pkg.sv
      - logic/xm_bus_if.sv
      - logic/xm_mem_regs_if.sv
      - logic/xm_bus_sync.sv
      - logic/xm_tick_timer.sv
      - logic/xm_mem_port.sv
      - logic/xm_reg_file.sv
      - logic/xm_reg_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_xm_reg_top.sv
